/* logic/sched_consts.svh */
// issue scheduler sizing constants
// the ROB depth, the issue window and the index width are shared by the
// packages and every module of the scheduler

`ifndef SCHED_CONSTS_SVH
`define SCHED_CONSTS_SVH

// ==================================================
// reorder buffer
// ==================================================

// entries in the ROB, a power of two so that indices wrap by themselves
`define SCHED_ROB_ENTRIES 16

// bits needed to name one ROB entry
`define SCHED_NDX_W 4

// ==================================================
// issue window
// ==================================================

// only the oldest entries are searched for issue
`define SCHED_WINDOW_SIZE 8

`endif

/* logic/sched_issue_pkg.sv */
// issue-side types of the scheduler
// the unit class an entry needs and the offset of a window slot from the head

`default_nettype none

`include "sched_consts.svh"

package sched_issue_pkg;

	// execution class of an entry
	// alu goes to alu0 or alu1, fc to the flow control unit, mem to agen
	typedef enum logic [1:0] {
		UC_ALU = 2'd0,
		UC_FC  = 2'd1,
		UC_MEM = 2'd2
	} unit_class_t;

	// slot 0 is the head, higher slots are younger
	typedef logic [$clog2(`SCHED_WINDOW_SIZE)-1:0] win_slot_t;

endpackage

`default_nettype wire

/* logic/sched_rob_pkg.sv */
// ROB-side types of the scheduler
// entry indices, one-bit-per-entry masks and the entry record itself

`default_nettype none

`include "sched_consts.svh"

package sched_rob_pkg;

	// index of one ROB entry
	typedef logic [`SCHED_NDX_W-1:0] rob_ndx_t;

	// one bit per ROB entry, bit n belongs to entry n
	typedef logic [`SCHED_ROB_ENTRIES-1:0] rob_bitmask_t;

	// ==================================================
	// entry record, 7 bits
	// ==================================================

	typedef struct packed {
		logic                         valid;
		sched_issue_pkg::unit_class_t uclass;
		// alu entry that must not run on alu1
		logic                         alu0_only;
		logic                         args_ready;
		logic                         issued;
		logic                         done;
	} rob_entry_t;

endpackage

`default_nettype wire

/* logic/sched_rob_state.sv */
// ROB entry state for the issue scheduler
// holds the entries and the head and tail pointers, applies dispatch, wakeup,
// completion, issue marking and in-order retire each cycle, flush wins over all

`default_nettype none

`include "sched_consts.svh"

module sched_rob_state (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         flush_i,
	input  logic                         dispatch_valid_i,
	input  sched_issue_pkg::unit_class_t dispatch_class_i,
	input  logic                         dispatch_alu0_only_i,
	input  logic                         dispatch_args_ready_i,
	output logic                         dispatch_ready_o,
	output sched_rob_pkg::rob_ndx_t      dispatch_idx_o,
	input  logic                         wakeup_valid_i,
	input  sched_rob_pkg::rob_ndx_t      wakeup_idx_i,
	input  logic                         complete_valid_i,
	input  sched_rob_pkg::rob_ndx_t      complete_idx_i,
	input  sched_rob_pkg::rob_bitmask_t  issue_mask_i,
	output sched_rob_pkg::rob_entry_t    entries_o [`SCHED_ROB_ENTRIES],
	output sched_rob_pkg::rob_ndx_t      head_o,
	output logic                         retire_valid_o,
	output sched_rob_pkg::rob_ndx_t      retire_idx_o
);
	import sched_rob_pkg::*;

	rob_entry_t           entries [`SCHED_ROB_ENTRIES];
	rob_ndx_t             head;
	rob_ndx_t             tail;
	logic [`SCHED_NDX_W:0] count;
	logic                 dispatch_fire;
	logic                 retire_now;

	// full only when every entry holds a live instruction
	assign dispatch_ready_o = (count != `SCHED_ROB_ENTRIES);
	assign dispatch_fire    = dispatch_valid_i & dispatch_ready_o;
	assign retire_now       = entries[head].valid & entries[head].done;

	assign dispatch_idx_o = tail;
	assign head_o         = head;
	assign entries_o      = entries;

	// ==================================================
	// per-entry updates
	// ==================================================

	// the tail entry is never live when dispatch fires, so a new entry
	// cannot collide with a wakeup, completion or retire of the old one
	always_ff @(posedge clk) begin
		for (int i = 0; i < `SCHED_ROB_ENTRIES; i++) begin
			if (rst || flush_i) begin
				entries[i].valid <= 1'b0;
			end else if (dispatch_fire && rob_ndx_t'(i) == tail) begin
				entries[i].valid      <= 1'b1;
				entries[i].uclass     <= dispatch_class_i;
				entries[i].alu0_only  <= dispatch_alu0_only_i;
				entries[i].args_ready <= dispatch_args_ready_i;
				entries[i].issued     <= 1'b0;
				entries[i].done       <= 1'b0;
			end else begin
				if (wakeup_valid_i && rob_ndx_t'(i) == wakeup_idx_i) begin
					entries[i].args_ready <= 1'b1;
				end
				if (complete_valid_i && rob_ndx_t'(i) == complete_idx_i) begin
					entries[i].done <= 1'b1;
				end
				// marked on the same edge that registers the issue strobe
				if (issue_mask_i[i]) begin
					entries[i].issued <= 1'b1;
				end
				if (retire_now && rob_ndx_t'(i) == head) begin
					entries[i].valid <= 1'b0;
				end
			end
		end
	end

	// ==================================================
	// pointers, occupancy and retire pulse
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			head           <= '0;
			tail           <= '0;
			count          <= '0;
			retire_valid_o <= 1'b0;
		end else begin
			// pointers wrap naturally at the ROB depth
			if (dispatch_fire) begin
				tail <= tail + 1'b1;
			end
			if (retire_now) begin
				head <= head + 1'b1;
			end
			count <= count + {{`SCHED_NDX_W{1'b0}}, dispatch_fire}
				- {{`SCHED_NDX_W{1'b0}}, retire_now};
			retire_valid_o <= retire_now;
		end
	end

	// only meaningful while retire_valid_o is high
	always_ff @(posedge clk) begin
		retire_idx_o <= head;
	end

endmodule

`default_nettype wire

/* logic/sched_window.sv */
// issue window of the scheduler
// lines up the oldest ROB entries from the head and works out, per slot,
// which unit may take the entry under the alu, fc and mem ordering rules

`default_nettype none

`include "sched_consts.svh"

module sched_window (
	input  sched_rob_pkg::rob_entry_t     entries_i [`SCHED_ROB_ENTRIES],
	input  sched_rob_pkg::rob_ndx_t       head_i,
	output sched_rob_pkg::rob_ndx_t       slot_ndx_o [`SCHED_WINDOW_SIZE],
	output logic [`SCHED_WINDOW_SIZE-1:0] alu_ok_o,
	output logic [`SCHED_WINDOW_SIZE-1:0] alu1_ok_o,
	output logic [`SCHED_WINDOW_SIZE-1:0] fc_ok_o,
	output logic [`SCHED_WINDOW_SIZE-1:0] mem_ok_o
);
	import sched_rob_pkg::*;
	import sched_issue_pkg::*;

	rob_entry_t                    slot_entry [`SCHED_WINDOW_SIZE];
	logic [`SCHED_WINDOW_SIZE-1:0] ready;
	logic [`SCHED_WINDOW_SIZE-1:0] fc_open;
	logic [`SCHED_WINDOW_SIZE-1:0] mem_open;
	logic [`SCHED_WINDOW_SIZE-1:0] older_fc_pend;
	logic [`SCHED_WINDOW_SIZE-1:0] older_mem_pend;

	always_comb begin
		win_slot_t off;
		for (int s = 0; s < `SCHED_WINDOW_SIZE; s++) begin
			off = win_slot_t'(s);
			slot_ndx_o[s] = rob_ndx_t'((head_i + off) % `SCHED_ROB_ENTRIES);
			slot_entry[s] = entries_i[slot_ndx_o[s]];
			ready[s] = slot_entry[s].valid & slot_entry[s].args_ready
				& ~slot_entry[s].issued & ~slot_entry[s].done;
			// an fc or mem entry holds back younger ones of its class until done
			fc_open[s] = slot_entry[s].valid & ~slot_entry[s].done
				& (slot_entry[s].uclass == UC_FC);
			mem_open[s] = slot_entry[s].valid & ~slot_entry[s].done
				& (slot_entry[s].uclass == UC_MEM);
		end

		// the window starts at the head, so every older entry is in a lower slot
		older_fc_pend[0]  = 1'b0;
		older_mem_pend[0] = 1'b0;
		for (int s = 1; s < `SCHED_WINDOW_SIZE; s++) begin
			older_fc_pend[s]  = older_fc_pend[s-1] | fc_open[s-1];
			older_mem_pend[s] = older_mem_pend[s-1] | mem_open[s-1];
		end

		for (int s = 0; s < `SCHED_WINDOW_SIZE; s++) begin
			alu_ok_o[s]  = ready[s] & (slot_entry[s].uclass == UC_ALU);
			alu1_ok_o[s] = alu_ok_o[s] & ~slot_entry[s].alu0_only;
			fc_ok_o[s]   = ready[s] & (slot_entry[s].uclass == UC_FC) & ~older_fc_pend[s];
			mem_ok_o[s]  = ready[s] & (slot_entry[s].uclass == UC_MEM) & ~older_mem_pend[s];
		end
	end

endmodule

`default_nettype wire

/* logic/sched_issue_select.sv */
// issue selector of the scheduler
// picks the oldest eligible window slot for alu0, alu1, fcu and agen, marks
// the picks in the ROB through issue_mask_o and registers the issue strobes

`default_nettype none

`include "sched_consts.svh"

module sched_issue_select (
	input  logic                          clk,
	input  logic                          rst,
	input  sched_rob_pkg::rob_ndx_t       slot_ndx_i [`SCHED_WINDOW_SIZE],
	input  logic [`SCHED_WINDOW_SIZE-1:0] alu_ok_i,
	input  logic [`SCHED_WINDOW_SIZE-1:0] alu1_ok_i,
	input  logic [`SCHED_WINDOW_SIZE-1:0] fc_ok_i,
	input  logic [`SCHED_WINDOW_SIZE-1:0] mem_ok_i,
	input  logic                          alu0_idle_i,
	input  logic                          alu1_idle_i,
	input  logic                          fcu_idle_i,
	input  logic                          agen_idle_i,
	output sched_rob_pkg::rob_bitmask_t   issue_mask_o,
	output sched_rob_pkg::rob_ndx_t       alu0_rndx_o,
	output sched_rob_pkg::rob_ndx_t       alu1_rndx_o,
	output sched_rob_pkg::rob_ndx_t       fcu_rndx_o,
	output sched_rob_pkg::rob_ndx_t       agen_rndx_o,
	output logic                          alu0_rndxv_o,
	output logic                          alu1_rndxv_o,
	output logic                          fcu_rndxv_o,
	output logic                          agen_rndxv_o
);
	import sched_rob_pkg::*;
	import sched_issue_pkg::*;

	logic                          alu0_hit;
	logic                          alu1_hit;
	logic                          fcu_hit;
	logic                          agen_hit;
	win_slot_t                     alu0_slot;
	win_slot_t                     alu1_slot;
	win_slot_t                     fcu_slot;
	win_slot_t                     agen_slot;
	logic [`SCHED_WINDOW_SIZE-1:0] alu1_req;

	// lowest requesting slot, which is the oldest entry
	function automatic win_slot_t oldest_slot(input logic [`SCHED_WINDOW_SIZE-1:0] req);
		win_slot_t slot;
		slot = '0;
		for (int s = `SCHED_WINDOW_SIZE - 1; s >= 0; s--) begin
			if (req[s]) begin
				slot = win_slot_t'(s);
			end
		end
		return slot;
	endfunction

	// ==================================================
	// per-unit priority search
	// ==================================================

	always_comb begin
		alu0_hit  = alu0_idle_i & (|alu_ok_i);
		alu0_slot = oldest_slot(alu_ok_i);

		// alu1 sees neither the alu0 pick nor any alu0-only entry
		alu1_req = alu1_ok_i;
		if (alu0_hit) begin
			alu1_req[alu0_slot] = 1'b0;
		end
		alu1_hit  = alu1_idle_i & (|alu1_req);
		alu1_slot = oldest_slot(alu1_req);

		fcu_hit   = fcu_idle_i & (|fc_ok_i);
		fcu_slot  = oldest_slot(fc_ok_i);
		agen_hit  = agen_idle_i & (|mem_ok_i);
		agen_slot = oldest_slot(mem_ok_i);
	end

	// the ROB marks these entries issued on the edge that raises the strobes
	always_comb begin
		issue_mask_o = '0;
		if (alu0_hit) begin
			issue_mask_o[slot_ndx_i[alu0_slot]] = 1'b1;
		end
		if (alu1_hit) begin
			issue_mask_o[slot_ndx_i[alu1_slot]] = 1'b1;
		end
		if (fcu_hit) begin
			issue_mask_o[slot_ndx_i[fcu_slot]] = 1'b1;
		end
		if (agen_hit) begin
			issue_mask_o[slot_ndx_i[agen_slot]] = 1'b1;
		end
	end

	// ==================================================
	// issue outputs
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			alu0_rndxv_o <= 1'b0;
			alu1_rndxv_o <= 1'b0;
			fcu_rndxv_o  <= 1'b0;
			agen_rndxv_o <= 1'b0;
			alu0_rndx_o  <= '0;
			alu1_rndx_o  <= '0;
			fcu_rndx_o   <= '0;
			agen_rndx_o  <= '0;
		end else begin
			alu0_rndxv_o <= alu0_hit;
			alu1_rndxv_o <= alu1_hit;
			fcu_rndxv_o  <= fcu_hit;
			agen_rndxv_o <= agen_hit;
			alu0_rndx_o  <= slot_ndx_i[alu0_slot];
			alu1_rndx_o  <= slot_ndx_i[alu1_slot];
			fcu_rndx_o   <= slot_ndx_i[fcu_slot];
			agen_rndx_o  <= slot_ndx_i[agen_slot];
		end
	end

endmodule

`default_nettype wire

/* logic/sched_top.sv */
// out-of-order issue scheduler for a 16-entry ROB
// joins the entry state, the oldest-first issue window and the per-unit
// selector for alu0, alu1, fcu and agen

`default_nettype none

`include "sched_consts.svh"

module sched_top (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         flush_i,
	input  logic                         dispatch_valid_i,
	input  sched_issue_pkg::unit_class_t dispatch_class_i,
	input  logic                         dispatch_alu0_only_i,
	input  logic                         dispatch_args_ready_i,
	output logic                         dispatch_ready_o,
	output sched_rob_pkg::rob_ndx_t      dispatch_idx_o,
	input  logic                         wakeup_valid_i,
	input  sched_rob_pkg::rob_ndx_t      wakeup_idx_i,
	input  logic                         complete_valid_i,
	input  sched_rob_pkg::rob_ndx_t      complete_idx_i,
	output logic                         retire_valid_o,
	output sched_rob_pkg::rob_ndx_t      retire_idx_o,
	input  logic                         alu0_idle_i,
	input  logic                         alu1_idle_i,
	input  logic                         fcu_idle_i,
	input  logic                         agen_idle_i,
	output sched_rob_pkg::rob_ndx_t      alu0_rndx_o,
	output sched_rob_pkg::rob_ndx_t      alu1_rndx_o,
	output sched_rob_pkg::rob_ndx_t      fcu_rndx_o,
	output sched_rob_pkg::rob_ndx_t      agen_rndx_o,
	output logic                         alu0_rndxv_o,
	output logic                         alu1_rndxv_o,
	output logic                         fcu_rndxv_o,
	output logic                         agen_rndxv_o
);
	import sched_rob_pkg::*;

	rob_entry_t                    entries [`SCHED_ROB_ENTRIES];
	rob_ndx_t                      head;
	rob_bitmask_t                  issue_mask;
	rob_ndx_t                      slot_ndx [`SCHED_WINDOW_SIZE];
	logic [`SCHED_WINDOW_SIZE-1:0] alu_ok;
	logic [`SCHED_WINDOW_SIZE-1:0] alu1_ok;
	logic [`SCHED_WINDOW_SIZE-1:0] fc_ok;
	logic [`SCHED_WINDOW_SIZE-1:0] mem_ok;
	logic                          alu0_go;
	logic                          alu1_go;
	logic                          fcu_go;
	logic                          agen_go;

	// nothing issues in a flush cycle, so no strobe follows a flush
	assign alu0_go = alu0_idle_i & ~flush_i;
	assign alu1_go = alu1_idle_i & ~flush_i;
	assign fcu_go  = fcu_idle_i & ~flush_i;
	assign agen_go = agen_idle_i & ~flush_i;

	sched_rob_state u_rob_state (
		.clk                   (clk),
		.rst                   (rst),
		.flush_i               (flush_i),
		.dispatch_valid_i      (dispatch_valid_i),
		.dispatch_class_i      (dispatch_class_i),
		.dispatch_alu0_only_i  (dispatch_alu0_only_i),
		.dispatch_args_ready_i (dispatch_args_ready_i),
		.dispatch_ready_o      (dispatch_ready_o),
		.dispatch_idx_o        (dispatch_idx_o),
		.wakeup_valid_i        (wakeup_valid_i),
		.wakeup_idx_i          (wakeup_idx_i),
		.complete_valid_i      (complete_valid_i),
		.complete_idx_i        (complete_idx_i),
		.issue_mask_i          (issue_mask),
		.entries_o             (entries),
		.head_o                (head),
		.retire_valid_o        (retire_valid_o),
		.retire_idx_o          (retire_idx_o)
	);

	sched_window u_window (
		.entries_i  (entries),
		.head_i     (head),
		.slot_ndx_o (slot_ndx),
		.alu_ok_o   (alu_ok),
		.alu1_ok_o  (alu1_ok),
		.fc_ok_o    (fc_ok),
		.mem_ok_o   (mem_ok)
	);

	sched_issue_select u_issue_select (
		.clk          (clk),
		.rst          (rst),
		.slot_ndx_i   (slot_ndx),
		.alu_ok_i     (alu_ok),
		.alu1_ok_i    (alu1_ok),
		.fc_ok_i      (fc_ok),
		.mem_ok_i     (mem_ok),
		.alu0_idle_i  (alu0_go),
		.alu1_idle_i  (alu1_go),
		.fcu_idle_i   (fcu_go),
		.agen_idle_i  (agen_go),
		.issue_mask_o (issue_mask),
		.alu0_rndx_o  (alu0_rndx_o),
		.alu1_rndx_o  (alu1_rndx_o),
		.fcu_rndx_o   (fcu_rndx_o),
		.agen_rndx_o  (agen_rndx_o),
		.alu0_rndxv_o (alu0_rndxv_o),
		.alu1_rndxv_o (alu1_rndxv_o),
		.fcu_rndxv_o  (fcu_rndxv_o),
		.agen_rndxv_o (agen_rndxv_o)
	);

endmodule

`default_nettype wire

/* tests/sched_assertions.sv */
// protocol assertions for the issue scheduler, bound to the top level
// checks unique issue indices, the full flag and the quiet cycle after a flush

`default_nettype none

`include "sched_consts.svh"

module sched_assertions (
	input logic                      clk,
	input logic                      rst,
	input logic                      flush_i,
	input logic                      dispatch_ready_o,
	input sched_rob_pkg::rob_entry_t entries_i [`SCHED_ROB_ENTRIES],
	input sched_rob_pkg::rob_ndx_t   alu0_rndx_o,
	input sched_rob_pkg::rob_ndx_t   alu1_rndx_o,
	input sched_rob_pkg::rob_ndx_t   fcu_rndx_o,
	input sched_rob_pkg::rob_ndx_t   agen_rndx_o,
	input logic                      alu0_rndxv_o,
	input logic                      alu1_rndxv_o,
	input logic                      fcu_rndxv_o,
	input logic                      agen_rndxv_o
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [`SCHED_ROB_ENTRIES-1:0] valid_bits;
	logic                          any_strobe;
	int                            fail_count = 0;

	always_comb begin
		for (int i = 0; i < `SCHED_ROB_ENTRIES; i++) begin
			valid_bits[i] = entries_i[i].valid;
		end
	end

	assign any_strobe = alu0_rndxv_o | alu1_rndxv_o | fcu_rndxv_o | agen_rndxv_o;

	unique_issue: assert property (@(posedge clk) disable iff (rst)
		!(alu0_rndxv_o && alu1_rndxv_o && alu0_rndx_o == alu1_rndx_o)
		&& !(alu0_rndxv_o && fcu_rndxv_o && alu0_rndx_o == fcu_rndx_o)
		&& !(alu0_rndxv_o && agen_rndxv_o && alu0_rndx_o == agen_rndx_o)
		&& !(alu1_rndxv_o && fcu_rndxv_o && alu1_rndx_o == fcu_rndx_o)
		&& !(alu1_rndxv_o && agen_rndxv_o && alu1_rndx_o == agen_rndx_o)
		&& !(fcu_rndxv_o && agen_rndxv_o && fcu_rndx_o == agen_rndx_o))
		else begin
			fail_count++;
			$error("two issue strobes name the same ROB entry");
		end

	ready_when_room: assert property (@(posedge clk) disable iff (rst)
		($countones(valid_bits) < `SCHED_ROB_ENTRIES) |-> dispatch_ready_o)
		else begin
			fail_count++;
			$error("dispatch_ready_o low while the ROB has a free entry");
		end

	quiet_after_flush: assert property (@(posedge clk) disable iff (rst)
		flush_i |=> !any_strobe)
		else begin
			fail_count++;
			$error("issue strobe in the cycle after a flush");
		end

endmodule

bind sched_top sched_assertions u_assertions (
	.clk              (clk),
	.rst              (rst),
	.flush_i          (flush_i),
	.dispatch_ready_o (dispatch_ready_o),
	.entries_i        (entries),
	.alu0_rndx_o      (alu0_rndx_o),
	.alu1_rndx_o      (alu1_rndx_o),
	.fcu_rndx_o       (fcu_rndx_o),
	.agen_rndx_o      (agen_rndx_o),
	.alu0_rndxv_o     (alu0_rndxv_o),
	.alu1_rndxv_o     (alu1_rndxv_o),
	.fcu_rndxv_o      (fcu_rndxv_o),
	.agen_rndxv_o     (agen_rndxv_o)
);

`default_nettype wire

/* tests/sched_checker.sv */
// scoreboard for the issue scheduler
// keeps a model ROB fed from the DUT inputs, predicts the issue picks and
// retire of every edge and compares them with the DUT outputs

`default_nettype none

`include "sched_consts.svh"

module sched_checker (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    flush_i,
	input  logic                    dispatch_valid_i,
	input  logic [1:0]              dispatch_class_i,
	input  logic                    dispatch_alu0_only_i,
	input  logic                    dispatch_args_ready_i,
	input  logic                    dispatch_ready_o,
	input  sched_rob_pkg::rob_ndx_t dispatch_idx_o,
	input  logic                    wakeup_valid_i,
	input  sched_rob_pkg::rob_ndx_t wakeup_idx_i,
	input  logic                    complete_valid_i,
	input  sched_rob_pkg::rob_ndx_t complete_idx_i,
	input  logic                    retire_valid_o,
	input  sched_rob_pkg::rob_ndx_t retire_idx_o,
	input  logic                    alu0_idle_i,
	input  logic                    alu1_idle_i,
	input  logic                    fcu_idle_i,
	input  logic                    agen_idle_i,
	input  logic [19:0]             issue_seen_i,
	output int                      err_count_o,
	output int                      check_count_o
);
	import sched_issue_pkg::*;

	timeunit 1ns;
	timeprecision 100ps;

	bit       m_valid [`SCHED_ROB_ENTRIES];
	bit [1:0] m_class [`SCHED_ROB_ENTRIES];
	bit       m_a0only [`SCHED_ROB_ENTRIES];
	bit       m_args [`SCHED_ROB_ENTRIES];
	bit       m_issued [`SCHED_ROB_ENTRIES];
	bit       m_done [`SCHED_ROB_ENTRIES];
	int       m_head;
	int       m_tail;
	int       m_count;
	bit [19:0] exp_pick;
	bit        exp_retire;
	bit [3:0]  exp_retire_idx;

	initial begin
		err_count_o   = 0;
		check_count_o = 0;
		exp_pick      = '0;
		exp_retire    = 1'b0;
	end

	// expected picks packed as {valid, index} for alu0, alu1, fcu, agen
	function automatic bit [19:0] predict_issue(input bit a0_go, input bit a1_go,
		input bit fc_go, input bit mem_go);
		bit [19:0] r;
		bit        fc_block;
		bit        mem_block;
		bit        rdy;
		int        n;
		r = '0;
		fc_block = 1'b0;
		mem_block = 1'b0;
		for (int w = 0; w < `SCHED_WINDOW_SIZE; w++) begin
			n = (m_head + w) % `SCHED_ROB_ENTRIES;
			rdy = m_valid[n] && m_args[n] && !m_issued[n] && !m_done[n];
			if (rdy && m_class[n] == UC_ALU) begin
				if (a0_go && !r[19]) begin
					r[19] = 1'b1;
					r[18:15] = n[3:0];
				end else if (a1_go && !m_a0only[n] && !r[14]) begin
					r[14] = 1'b1;
					r[13:10] = n[3:0];
				end
			end
			if (rdy && m_class[n] == UC_FC && fc_go && !fc_block && !r[9]) begin
				r[9] = 1'b1;
				r[8:5] = n[3:0];
			end
			if (rdy && m_class[n] == UC_MEM && mem_go && !mem_block && !r[4]) begin
				r[4] = 1'b1;
				r[3:0] = n[3:0];
			end
			// an unfinished fc or mem entry holds back all younger ones of its class
			if (m_valid[n] && !m_done[n] && m_class[n] == UC_FC) begin
				fc_block = 1'b1;
			end
			if (m_valid[n] && !m_done[n] && m_class[n] == UC_MEM) begin
				mem_block = 1'b1;
			end
		end
		return r;
	endfunction

	task automatic clear_model();
		for (int i = 0; i < `SCHED_ROB_ENTRIES; i++) begin
			m_valid[i] = 1'b0;
		end
		m_head = 0;
		m_tail = 0;
		m_count = 0;
	endtask

	task automatic mark_issued(input bit v, input bit [3:0] idx);
		if (v) begin
			m_issued[idx] = 1'b1;
		end
	endtask

	// ==================================================
	// model update at each rising edge
	// ==================================================

	always @(posedge clk) begin
		if (rst) begin
			clear_model();
			exp_pick = '0;
			exp_retire = 1'b0;
		end else begin
			exp_pick = predict_issue(alu0_idle_i & ~flush_i, alu1_idle_i & ~flush_i,
				fcu_idle_i & ~flush_i, agen_idle_i & ~flush_i);
			// a flush outranks the retire of a finished head
			exp_retire = !flush_i && m_valid[m_head] && m_done[m_head];
			exp_retire_idx = m_head[3:0];
			if (flush_i) begin
				clear_model();
			end else begin
				if (wakeup_valid_i) begin
					m_args[wakeup_idx_i] = 1'b1;
				end
				if (complete_valid_i) begin
					m_done[complete_idx_i] = 1'b1;
				end
				mark_issued(exp_pick[19], exp_pick[18:15]);
				mark_issued(exp_pick[14], exp_pick[13:10]);
				mark_issued(exp_pick[9], exp_pick[8:5]);
				mark_issued(exp_pick[4], exp_pick[3:0]);
				if (exp_retire) begin
					m_valid[m_head] = 1'b0;
					m_head = (m_head + 1) % `SCHED_ROB_ENTRIES;
					m_count--;
				end
				if (dispatch_valid_i && m_count + (exp_retire ? 1 : 0) != `SCHED_ROB_ENTRIES) begin
					m_valid[m_tail] = 1'b1;
					m_class[m_tail] = dispatch_class_i;
					m_a0only[m_tail] = dispatch_alu0_only_i;
					m_args[m_tail] = dispatch_args_ready_i;
					m_issued[m_tail] = 1'b0;
					m_done[m_tail] = 1'b0;
					m_tail = (m_tail + 1) % `SCHED_ROB_ENTRIES;
					m_count++;
				end
			end
		end
	end

	// ==================================================
	// comparison away from the edge
	// ==================================================

	always @(negedge clk) begin
		bit [19:0] got;
		got = issue_seen_i;
		// an index only matters while its strobe is high
		if (!got[19]) got[18:15] = '0;
		if (!got[14]) got[13:10] = '0;
		if (!got[9]) got[8:5] = '0;
		if (!got[4]) got[3:0] = '0;
		check_count_o++;
		if (got != exp_pick) begin
			err_count_o++;
			$display("MISMATCH %0t: issue {v,idx} alu0 alu1 fcu agen expected %h got %h",
				$time, exp_pick, got);
		end
		if (retire_valid_o !== exp_retire
			|| (exp_retire && retire_idx_o !== exp_retire_idx)) begin
			err_count_o++;
			$display("MISMATCH %0t: retire expected %0b/%0d got %0b/%0d", $time,
				exp_retire, exp_retire_idx, retire_valid_o, retire_idx_o);
		end
		if (!rst && (dispatch_ready_o !== (m_count != `SCHED_ROB_ENTRIES)
			|| dispatch_idx_o !== m_tail[3:0])) begin
			err_count_o++;
			$display("MISMATCH %0t: dispatch ready/idx expected %0b/%0d got %0b/%0d",
				$time, m_count != `SCHED_ROB_ENTRIES, m_tail, dispatch_ready_o,
				dispatch_idx_o);
		end
	end

endmodule

`default_nettype wire

/* tests/sched_tb.sv */
// testbench for the issue scheduler
// drives dispatch, wakeup, completion, idle and flush traffic through six tests

`default_nettype none

module sched_tb;
	import sched_issue_pkg::*;
	import sched_rob_pkg::*;

	timeunit 1ns;
	timeprecision 100ps;

	// cycle budgets of the six tests
	localparam int TEST_CYCLES = 40 + 40 + 40 + 50 + 80 + 40;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 100;

	logic clk = 1'b0;
	logic rst;
	logic flush_i;
	logic dispatch_valid_i;
	unit_class_t dispatch_class_i;
	logic dispatch_alu0_only_i;
	logic dispatch_args_ready_i;
	logic dispatch_ready_o;
	rob_ndx_t dispatch_idx_o;
	logic wakeup_valid_i;
	rob_ndx_t wakeup_idx_i;
	logic complete_valid_i;
	rob_ndx_t complete_idx_i;
	logic retire_valid_o;
	rob_ndx_t retire_idx_o;
	logic alu0_idle_i, alu1_idle_i, fcu_idle_i, agen_idle_i;
	rob_ndx_t alu0_rndx_o, alu1_rndx_o, fcu_rndx_o, agen_rndx_o;
	logic alu0_rndxv_o, alu1_rndxv_o, fcu_rndxv_o, agen_rndxv_o;
	int err_count;
	int check_count;

	integer seed = 32'hf5a9;
	int cycles = 0;
	int outstanding = 0;
	bit auto_complete = 1'b1;
	rob_ndx_t in_flight [$];
	int tests_run = 0;
	int tests_failed = 0;
	int errs_at_start = 0;
	rob_ndx_t held [8];

	always #4 clk = ~clk;

	sched_top uut (.*);

	sched_checker chk (
		.clk (clk), .rst (rst), .flush_i (flush_i),
		.dispatch_valid_i (dispatch_valid_i), .dispatch_class_i (dispatch_class_i),
		.dispatch_alu0_only_i (dispatch_alu0_only_i),
		.dispatch_args_ready_i (dispatch_args_ready_i),
		.dispatch_ready_o (dispatch_ready_o), .dispatch_idx_o (dispatch_idx_o),
		.wakeup_valid_i (wakeup_valid_i), .wakeup_idx_i (wakeup_idx_i),
		.complete_valid_i (complete_valid_i), .complete_idx_i (complete_idx_i),
		.retire_valid_o (retire_valid_o), .retire_idx_o (retire_idx_o),
		.alu0_idle_i (alu0_idle_i), .alu1_idle_i (alu1_idle_i),
		.fcu_idle_i (fcu_idle_i), .agen_idle_i (agen_idle_i),
		.issue_seen_i ({alu0_rndxv_o, alu0_rndx_o, alu1_rndxv_o, alu1_rndx_o,
			fcu_rndxv_o, fcu_rndx_o, agen_rndxv_o, agen_rndx_o}),
		.err_count_o (err_count), .check_count_o (check_count)
	);

	// run limit derived from the test budgets
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	// one clock, with inputs changed 1 ns after the edge
	task automatic tick();
		bit fired;
		bit flushed;
		int k;
		fired = dispatch_valid_i & dispatch_ready_o;
		flushed = flush_i;
		@(posedge clk);
		#1;
		if (fired) outstanding++;
		if (alu0_rndxv_o) in_flight.push_back(alu0_rndx_o);
		if (alu1_rndxv_o) in_flight.push_back(alu1_rndx_o);
		if (fcu_rndxv_o) in_flight.push_back(fcu_rndx_o);
		if (agen_rndxv_o) in_flight.push_back(agen_rndx_o);
		if (retire_valid_o) outstanding--;
		dispatch_valid_i = 1'b0;
		wakeup_valid_i = 1'b0;
		complete_valid_i = 1'b0;
		flush_i = 1'b0;
		if (flushed) begin
			outstanding = 0;
			in_flight.delete();
		end
		if (auto_complete && in_flight.size() > 0 && ($random(seed) & 1)) begin
			k = $unsigned($random(seed)) % in_flight.size();
			complete_valid_i = 1'b1;
			complete_idx_i = in_flight[k];
			in_flight.delete(k);
		end
	endtask

	task automatic dispatch_entry(input unit_class_t cls, input bit a0, input bit rdy,
		output rob_ndx_t idx);
		while (!dispatch_ready_o) begin
			tick();
		end
		dispatch_valid_i = 1'b1;
		dispatch_class_i = cls;
		dispatch_alu0_only_i = a0;
		dispatch_args_ready_i = rdy;
		idx = dispatch_idx_o;
		tick();
	endtask

	task automatic set_idle(input bit a0, input bit a1, input bit fc, input bit ag);
		alu0_idle_i = a0;
		alu1_idle_i = a1;
		fcu_idle_i = fc;
		agen_idle_i = ag;
	endtask

	task automatic drain_rob();
		while (outstanding != 0) begin
			tick();
		end
		tick();
	endtask

	task automatic start_test();
		errs_at_start = err_count;
	endtask

	task automatic report_test(input string name);
		int errs;
		errs = err_count - errs_at_start;
		tests_run++;
		if (errs != 0) tests_failed++;
		$display("test %0d %s: %s (%0d mismatches)", tests_run, name,
			errs == 0 ? "ok" : "FAILED", errs);
	endtask

	initial begin
		rob_ndx_t idx;
		rst = 1'b1;
		flush_i = 1'b0;
		dispatch_valid_i = 1'b0;
		dispatch_class_i = UC_ALU;
		dispatch_alu0_only_i = 1'b0;
		dispatch_args_ready_i = 1'b0;
		wakeup_valid_i = 1'b0;
		wakeup_idx_i = '0;
		complete_valid_i = 1'b0;
		complete_idx_i = '0;
		set_idle(1, 1, 1, 1);
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;

		// alu burst held back, then released two per cycle
		start_test();
		set_idle(0, 0, 1, 1);
		for (int i = 0; i < 8; i++) begin
			dispatch_entry(UC_ALU, (i % 3) == 1, 1'b1, idx);
		end
		set_idle(1, 1, 1, 1);
		drain_rob();
		report_test("alu burst");

		// operands arrive late
		start_test();
		for (int i = 0; i < 4; i++) begin
			dispatch_entry(UC_ALU, $random(seed) & 1, 1'b0, held[i]);
		end
		dispatch_entry(UC_MEM, 1'b0, 1'b0, held[4]);
		repeat (3) tick();
		for (int i = 4; i >= 0; i--) begin
			wakeup_valid_i = 1'b1;
			wakeup_idx_i = held[i];
			tick();
			tick();
		end
		drain_rob();
		report_test("wakeup");

		start_test();
		for (int i = 0; i < 6; i++) begin
			dispatch_entry(UC_MEM, 1'b0, 1'b1, idx);
		end
		drain_rob();
		report_test("mem order");

		start_test();
		for (int i = 0; i < 5; i++) begin
			dispatch_entry(UC_FC, 1'b0, 1'b1, idx);
		end
		drain_rob();
		report_test("fc serial");

		// a stalled mem head lets the ROB fill up
		start_test();
		set_idle(1, 1, 1, 0);
		dispatch_entry(UC_MEM, 1'b0, 1'b1, idx);
		for (int i = 0; i < 15; i++) begin
			dispatch_entry(UC_ALU, 1'b0, 1'b1, idx);
		end
		repeat (3) begin
			dispatch_valid_i = 1'b1;
			tick();
		end
		set_idle(1, 1, 1, 1);
		drain_rob();
		report_test("back-pressure and full");

		start_test();
		auto_complete = 1'b0;
		for (int i = 0; i < 6; i++) begin
			dispatch_entry(i == 5 ? UC_FC : UC_ALU, 1'b0, i != 3 && i != 4, held[i]);
		end
		// the head completes one cycle early and would retire in the flush cycle
		complete_valid_i = 1'b1;
		complete_idx_i = held[0];
		tick();
		flush_i = 1'b1;
		tick();
		repeat (3) tick();
		auto_complete = 1'b1;
		dispatch_entry(UC_ALU, 1'b0, 1'b1, idx);
		dispatch_entry(UC_ALU, 1'b0, 1'b1, idx);
		drain_rob();
		report_test("flush");

		$display("tests %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
			tests_run, tests_failed, check_count, err_count, uut.u_assertions.fail_count);
		if (tests_failed == 0 && err_count == 0 && uut.u_assertions.fail_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+logic
logic/sched_issue_pkg.sv
logic/sched_rob_pkg.sv
logic/sched_rob_state.sv
logic/sched_window.sv
logic/sched_issue_select.sv
logic/sched_top.sv
tests/sched_assertions.sv
tests/sched_checker.sv
tests/sched_tb.sv

/* Bender.yml */
package:
  name: sched

sources:
  - include_dirs:
      - logic
    files:
      - logic/sched_issue_pkg.sv
      - logic/sched_rob_pkg.sv
      - logic/sched_rob_state.sv
      - logic/sched_window.sv
      - logic/sched_issue_select.sv
      - logic/sched_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/sched_assertions.sv
      - tests/sched_checker.sv
      - tests/sched_tb.sv
